// File: logic/shifter_params.svh
// Shift unit widths and register map
`ifndef SHIFTER_PARAMS_SVH
`define SHIFTER_PARAMS_SVH

// Operand and bus data width
`define SHIFTER_DATA_WIDTH 16

// Byte address into the register window
`define SHIFTER_ADDR_WIDTH 4

// Shift amount covers 0..15
`define SHIFTER_AMT_WIDTH 4

// One strobe bit per data byte
`define SHIFTER_STRB_WIDTH 2

// Register byte offsets, word aligned
`define REG_DATA_OFFSET   4'h0
`define REG_SHIFT_OFFSET  4'h4
`define REG_MODE_OFFSET   4'h8
`define REG_RESULT_OFFSET 4'hC

`endif

// File: logic/shifter_pkg.sv
// Shift unit shared types
`default_nettype none

`include "shifter_params.svh"

package shifter_pkg;

    // Operation select as held in the mode register
    typedef enum logic [1:0] {
        OP_SLL = 2'd0,
        OP_SRL = 2'd1,
        OP_SRA = 2'd2,
        OP_ROR = 2'd3
    } shift_op_e;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Write request into the register bank
    typedef struct packed {
        logic [`SHIFTER_ADDR_WIDTH-1:0] addr;
        logic [`SHIFTER_DATA_WIDTH-1:0] data;
        logic [`SHIFTER_STRB_WIDTH-1:0] strb;
    } reg_wr_t;

    // Shifter configuration, driven continuously
    typedef struct packed {
        logic [`SHIFTER_DATA_WIDTH-1:0] operand;
        logic [`SHIFTER_AMT_WIDTH-1:0]  amount;
        shift_op_e                      op;
    } shift_cfg_t;

endpackage

`default_nettype wire

// File: logic/axil_write_port.sv
// AXI4-Lite write channel front end
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module axil_write_port (
    input  wire                             ACLK,
    input  wire                             ARESETN,
    input  wire [`SHIFTER_ADDR_WIDTH-1:0]   awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire [`SHIFTER_DATA_WIDTH-1:0]   wdata,
    input  wire [`SHIFTER_STRB_WIDTH-1:0]   wstrb,
    input  wire                             wvalid,
    output logic                            wready,
    output shifter_pkg::axil_resp_e         bresp,
    output logic                            bvalid,
    input  wire                             bready,
    output logic                            wr_valid,
    output shifter_pkg::reg_wr_t            wr_req,
    input  wire shifter_pkg::axil_resp_e    wr_resp
);

    import shifter_pkg::*;

    logic    aw_full;
    logic    w_full;
    logic    aw_full_nxt;
    logic    w_full_nxt;
    logic    bvalid_nxt;
    logic    aw_hs;
    logic    w_hs;
    reg_wr_t wr_q;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // Address and data both held, so the write goes out this cycle
    assign wr_valid = aw_full && w_full;
    assign wr_req   = wr_q;

    always_comb begin
        aw_full_nxt = (aw_full || aw_hs) && !wr_valid;
        w_full_nxt  = (w_full || w_hs) && !wr_valid;
        bvalid_nxt  = wr_valid || (bvalid && !bready);
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            aw_full <= aw_full_nxt;
            w_full  <= w_full_nxt;
            bvalid  <= bvalid_nxt;
            if (wr_valid) begin
                bresp <= wr_resp;
            end
            // No new address or data while a response is outstanding
            awready <= !aw_full_nxt && !bvalid_nxt;
            wready  <= !w_full_nxt && !bvalid_nxt;
        end
    end

    // Address and data captured independently, in either order
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            wr_q.addr <= awaddr;
        end
        if (w_hs) begin
            wr_q.data <= wdata;
            wr_q.strb <= wstrb;
        end
    end

    // Response held under back-pressure
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        bvalid && !bready |=> bvalid && $stable(bresp));

    // Register bank sees no write until the previous response is taken
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        bvalid |-> !wr_valid);

endmodule

`default_nettype wire

// File: logic/axil_read_port.sv
// AXI4-Lite read channel front end
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module axil_read_port (
    input  wire                             ACLK,
    input  wire                             ARESETN,
    input  wire [`SHIFTER_ADDR_WIDTH-1:0]   araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output logic [`SHIFTER_DATA_WIDTH-1:0]  rdata,
    output shifter_pkg::axil_resp_e         rresp,
    output logic                            rvalid,
    input  wire                             rready,
    output logic [`SHIFTER_ADDR_WIDTH-1:0]  rd_addr,
    input  wire [`SHIFTER_DATA_WIDTH-1:0]   rd_data
);

    import shifter_pkg::*;

    logic ar_hs;
    logic rvalid_nxt;

    assign ar_hs = arvalid && arready;

    // Register bank mux looks at the bus address directly
    assign rd_addr = araddr;

    // Every readable offset answers OKAY
    assign rresp = RESP_OKAY;

    assign rvalid_nxt = ar_hs || (rvalid && !rready);

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else begin
            rvalid <= rvalid_nxt;
            // One read in flight
            arready <= !rvalid_nxt;
        end
    end

    // Sample the mux on the address handshake
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rdata <= rd_data;
        end
    end

    // Read data held until the master takes it
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: logic/shifter_regs.sv
// Shifter register bank
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module shifter_regs (
    input  wire                             ACLK,
    input  wire                             ARESETN,
    input  wire                             wr_valid,
    input  wire shifter_pkg::reg_wr_t       wr_req,
    output shifter_pkg::axil_resp_e         wr_resp,
    input  wire [`SHIFTER_ADDR_WIDTH-1:0]   rd_addr,
    output logic [`SHIFTER_DATA_WIDTH-1:0]  rd_data,
    output shifter_pkg::shift_cfg_t         cfg,
    input  wire [`SHIFTER_DATA_WIDTH-1:0]   result
);

    import shifter_pkg::*;

    logic [`SHIFTER_DATA_WIDTH-1:0] operand_q;
    logic [`SHIFTER_AMT_WIDTH-1:0]  amount_q;
    shift_op_e                      op_q;
    logic [`SHIFTER_ADDR_WIDTH-1:0] wr_word;
    logic [`SHIFTER_ADDR_WIDTH-1:0] rd_word;

    // Only bits 3..2 select a register
    assign wr_word = {wr_req.addr[`SHIFTER_ADDR_WIDTH-1:2], 2'b00};
    assign rd_word = {rd_addr[`SHIFTER_ADDR_WIDTH-1:2], 2'b00};

    // Result is read-only
    assign wr_resp = (wr_word == `REG_RESULT_OFFSET) ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            operand_q <= '0;
            amount_q  <= '0;
            op_q      <= OP_SLL;
        end else if (wr_valid) begin
            case (wr_word)
                `REG_DATA_OFFSET: begin
                    for (int i = 0; i < `SHIFTER_STRB_WIDTH; i++) begin
                        if (wr_req.strb[i]) begin
                            operand_q[i*8 +: 8] <= wr_req.data[i*8 +: 8];
                        end
                    end
                end
                `REG_SHIFT_OFFSET: begin
                    if (wr_req.strb[0]) begin
                        amount_q <= wr_req.data[`SHIFTER_AMT_WIDTH-1:0];
                    end
                end
                `REG_MODE_OFFSET: begin
                    if (wr_req.strb[0]) begin
                        op_q <= shift_op_e'(wr_req.data[1:0]);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Read mux with narrow fields zero extended
    always_comb begin
        case (rd_word)
            `REG_DATA_OFFSET:   rd_data = operand_q;
            `REG_SHIFT_OFFSET:  rd_data = {{(`SHIFTER_DATA_WIDTH-`SHIFTER_AMT_WIDTH){1'b0}},
                                           amount_q};
            `REG_MODE_OFFSET:   rd_data = {{(`SHIFTER_DATA_WIDTH-2){1'b0}}, op_q};
            `REG_RESULT_OFFSET: rd_data = result;
            default:            rd_data = '0;
        endcase
    end

    always_comb begin
        cfg.operand = operand_q;
        cfg.amount  = amount_q;
        cfg.op      = op_q;
    end

endmodule

`default_nettype wire

// File: logic/barrel_shifter.sv
// Registered barrel shifter
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module barrel_shifter (
    input  wire                             ACLK,
    input  wire                             ARESETN,
    input  wire shifter_pkg::shift_cfg_t    cfg,
    output logic [`SHIFTER_DATA_WIDTH-1:0]  result
);

    import shifter_pkg::*;

    logic [2*`SHIFTER_DATA_WIDTH-1:0] doubled;
    logic [2*`SHIFTER_DATA_WIDTH-1:0] rotated;
    logic [`SHIFTER_DATA_WIDTH-1:0]   result_nxt;

    // Rotate as a right shift of the doubled operand
    assign doubled = {cfg.operand, cfg.operand};
    assign rotated = doubled >> cfg.amount;

    always_comb begin
        case (cfg.op)
            OP_SLL:  result_nxt = cfg.operand << cfg.amount;
            OP_SRL:  result_nxt = cfg.operand >> cfg.amount;
            OP_SRA:  result_nxt = $signed(cfg.operand) >>> cfg.amount;
            OP_ROR:  result_nxt = rotated[`SHIFTER_DATA_WIDTH-1:0];
            default: result_nxt = '0;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            result <= '0;
        end else begin
            result <= result_nxt;
        end
    end

    // Mode register always holds a defined op
    assert property (@(posedge ACLK) disable iff (!ARESETN)
        !$isunknown(cfg.op));

endmodule

`default_nettype wire

// File: logic/axil_shifter.sv
// AXI4-Lite shift unit top
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module axil_shifter (
    input  wire                             ACLK,
    input  wire                             ARESETN,
    input  wire [`SHIFTER_ADDR_WIDTH-1:0]   awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire [`SHIFTER_DATA_WIDTH-1:0]   wdata,
    input  wire [`SHIFTER_STRB_WIDTH-1:0]   wstrb,
    input  wire                             wvalid,
    output logic                            wready,
    output shifter_pkg::axil_resp_e         bresp,
    output logic                            bvalid,
    input  wire                             bready,
    input  wire [`SHIFTER_ADDR_WIDTH-1:0]   araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output logic [`SHIFTER_DATA_WIDTH-1:0]  rdata,
    output shifter_pkg::axil_resp_e         rresp,
    output logic                            rvalid,
    input  wire                             rready
);

    import shifter_pkg::*;

    logic                           wr_valid;
    reg_wr_t                        wr_req;
    axil_resp_e                     wr_resp;
    logic [`SHIFTER_ADDR_WIDTH-1:0] rd_addr;
    logic [`SHIFTER_DATA_WIDTH-1:0] rd_data;
    shift_cfg_t                     cfg;
    logic [`SHIFTER_DATA_WIDTH-1:0] result;

    axil_write_port write_port_inst (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .wr_valid (wr_valid),
        .wr_req   (wr_req),
        .wr_resp  (wr_resp)
    );

    axil_read_port read_port_inst (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    shifter_regs regs_inst (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .wr_valid (wr_valid),
        .wr_req   (wr_req),
        .wr_resp  (wr_resp),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .cfg      (cfg),
        .result   (result)
    );

    barrel_shifter shifter_inst (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .cfg     (cfg),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: testbench/tb_axil_shifter.sv
// AXI4-Lite shift unit testbench
`timescale 1ns/1ps
`default_nettype none

`include "shifter_params.svh"

module tb_axil_shifter;

    import shifter_pkg::*;

    localparam int HS_LIMIT    = 50;
    localparam int NUM_TRANS   = 400;
    localparam int CYCLE_LIMIT = NUM_TRANS * 60;

    logic                           ACLK;
    logic                           ARESETN;
    logic [`SHIFTER_ADDR_WIDTH-1:0] awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [`SHIFTER_DATA_WIDTH-1:0] wdata;
    logic [`SHIFTER_STRB_WIDTH-1:0] wstrb;
    logic                           wvalid;
    logic                           wready;
    axil_resp_e                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [`SHIFTER_ADDR_WIDTH-1:0] araddr;
    logic                           arvalid;
    logic                           arready;
    logic [`SHIFTER_DATA_WIDTH-1:0] rdata;
    axil_resp_e                     rresp;
    logic                           rvalid;
    logic                           rready;

    integer seed;
    int     cycle_count = 0;

    // Reference copy of the register bank
    logic [`SHIFTER_DATA_WIDTH-1:0] m_operand;
    logic [`SHIFTER_AMT_WIDTH-1:0]  m_amount;
    shift_op_e                      m_op;

    axil_shifter axil_shifter_inst (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #2 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [`SHIFTER_DATA_WIDTH-1:0] got,
                              input logic [`SHIFTER_DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input shift_op_e got, input shift_op_e exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [`SHIFTER_DATA_WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[`SHIFTER_DATA_WIDTH-1:0];
    endfunction

    // Strobe rules of the register map, returns the expected response
    function automatic axil_resp_e apply_write(input logic [`SHIFTER_ADDR_WIDTH-1:0] addr,
                                               input logic [`SHIFTER_DATA_WIDTH-1:0] data,
                                               input logic [`SHIFTER_STRB_WIDTH-1:0] strb);
        axil_resp_e resp;
        resp = RESP_OKAY;
        case ({addr[3:2], 2'b00})
            `REG_DATA_OFFSET: begin
                if (strb[0]) m_operand[7:0] = data[7:0];
                if (strb[1]) m_operand[15:8] = data[15:8];
            end
            `REG_SHIFT_OFFSET: if (strb[0]) m_amount = data[3:0];
            `REG_MODE_OFFSET:  if (strb[0]) m_op = shift_op_e'(data[1:0]);
            default:           resp = RESP_SLVERR;
        endcase
        return resp;
    endfunction

    // Bit by bit: each result bit names the operand bit it comes from
    function automatic logic [`SHIFTER_DATA_WIDTH-1:0] shifted_value();
        logic [`SHIFTER_DATA_WIDTH-1:0] r;
        int                             amt;
        int                             src;
        amt = int'(m_amount);
        for (int i = 0; i < `SHIFTER_DATA_WIDTH; i++) begin
            src = i + amt;
            case (m_op)
                OP_SLL:  r[4'(i)] = (i >= amt) ? m_operand[4'(i - amt)] : 1'b0;
                OP_SRL:  r[4'(i)] = (src < 16) ? m_operand[4'(src)] : 1'b0;
                OP_SRA:  r[4'(i)] = (src < 16) ? m_operand[4'(src)] : m_operand[15];
                default: r[4'(i)] = m_operand[4'(src % 16)];
            endcase
        end
        return r;
    endfunction

    function automatic logic [`SHIFTER_DATA_WIDTH-1:0] expected_read(
        input logic [`SHIFTER_ADDR_WIDTH-1:0] addr);
        case ({addr[3:2], 2'b00})
            `REG_DATA_OFFSET:  return m_operand;
            `REG_SHIFT_OFFSET: return {12'd0, m_amount};
            `REG_MODE_OFFSET:  return {14'd0, m_op};
            default:           return shifted_value();
        endcase
    endfunction

    // AW and W open after their own delays, B is held off for b_dly cycles
    task automatic bus_write(input logic [3:0] addr, input logic [15:0] data,
                             input logic [1:0] strb, input int aw_dly, input int w_dly,
                             input int b_dly, input bit preload, input logic [3:0] pre_addr,
                             output axil_resp_e resp);
        int         cyc;
        bit         aw_done;
        bit         w_done;
        bit         b_done;
        bit         stalled;
        axil_resp_e held_resp;
        cyc       = 0;
        aw_done   = 1'b0;
        w_done    = 1'b0;
        b_done    = 1'b0;
        stalled   = 1'b0;
        held_resp = RESP_OKAY;
        resp      = RESP_OKAY;
        while (!(aw_done && w_done)) begin
            if (cyc == aw_dly) begin
                awaddr  <= addr;
                awvalid <= 1'b1;
            end
            if (cyc == w_dly) begin
                wdata  <= data;
                wstrb  <= strb;
                wvalid <= 1'b1;
            end
            @(posedge ACLK);
            cyc++;
            if (awvalid && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
            if (cyc > aw_dly + w_dly + HS_LIMIT) begin
                $display("write address or data not accepted within %0d cycles", HS_LIMIT);
                abort_run();
            end
        end
        cyc = 0;
        while (!b_done) begin
            if (cyc == b_dly) bready <= 1'b1;
            @(posedge ACLK);
            cyc++;
            // No new write while a response waits
            if (bvalid) begin
                check_flag("awready", awready, 1'b0);
                check_flag("wready", wready, 1'b0);
            end
            if (bvalid && bready) begin
                resp = bresp;
                bready <= 1'b0;
                b_done = 1'b1;
            end else begin
                if (stalled) begin
                    check_flag("bvalid", bvalid, 1'b1);
                    check_resp("bresp", bresp, held_resp);
                end
                if (bvalid) begin
                    stalled   = 1'b1;
                    held_resp = bresp;
                    if (preload) begin
                        awaddr  <= pre_addr;
                        awvalid <= 1'b1;
                    end
                end
                if (cyc > b_dly + HS_LIMIT) begin
                    $display("write response not returned within %0d cycles", HS_LIMIT);
                    abort_run();
                end
            end
        end
    endtask

    task automatic bus_read(input logic [3:0] addr, input int ar_dly, input int r_dly,
                            output logic [15:0] data, output axil_resp_e resp);
        int          cyc;
        bit          done;
        bit          stalled;
        logic [15:0] held;
        cyc     = 0;
        done    = 1'b0;
        stalled = 1'b0;
        held    = '0;
        data    = '0;
        resp    = RESP_OKAY;
        while (!done) begin
            if (cyc == ar_dly) begin
                araddr  <= addr;
                arvalid <= 1'b1;
            end
            @(posedge ACLK);
            cyc++;
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                done = 1'b1;
            end else if (cyc > ar_dly + HS_LIMIT) begin
                $display("read address not accepted within %0d cycles", HS_LIMIT);
                abort_run();
            end
        end
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            if (cyc == r_dly) rready <= 1'b1;
            @(posedge ACLK);
            cyc++;
            if (rvalid) check_flag("arready", arready, 1'b0);
            if (rvalid && rready) begin
                data = rdata;
                resp = rresp;
                rready <= 1'b0;
                done = 1'b1;
            end else begin
                if (stalled) begin
                    check_flag("rvalid", rvalid, 1'b1);
                    check_data("rdata", rdata, held);
                end
                if (rvalid) begin
                    stalled = 1'b1;
                    held    = rdata;
                end
                if (cyc > r_dly + HS_LIMIT) begin
                    $display("read data not returned within %0d cycles", HS_LIMIT);
                    abort_run();
                end
            end
        end
    endtask

    task automatic write_checked(input logic [3:0] addr, input logic [15:0] data,
                                 input logic [1:0] strb, input int aw_dly, input int w_dly,
                                 input int b_dly, input bit preload, input logic [3:0] pre_addr);
        axil_resp_e resp;
        axil_resp_e exp;
        bus_write(addr, data, strb, aw_dly, w_dly, b_dly, preload, pre_addr, resp);
        exp = apply_write(addr, data, strb);
        check_resp("bresp", resp, exp);
    endtask

    task automatic read_checked(input logic [3:0] addr, input int ar_dly, input int r_dly);
        logic [15:0] data;
        axil_resp_e  resp;
        bus_read(addr, ar_dly, r_dly, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_data("rdata", data, expected_read(addr));
        if ({addr[3:2], 2'b00} == `REG_MODE_OFFSET) begin
            check_op("rdata op", shift_op_e'(data[1:0]), m_op);
        end
    endtask

    initial begin
        logic [3:0]  addr;
        logic [3:0]  next_addr;
        logic [15:0] data;
        int          dly;
        seed      = 32'hc69b;
        ACLK      = 1'b0;
        ARESETN   = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        m_operand = '0;
        m_amount  = '0;
        m_op      = OP_SLL;

        // Idle state, sampled while reset is still applied
        repeat (3) @(posedge ACLK);
        check_flag("awready", awready, 1'b0);
        check_flag("wready", wready, 1'b0);
        check_flag("arready", arready, 1'b0);
        check_flag("bvalid", bvalid, 1'b0);
        check_flag("rvalid", rvalid, 1'b0);
        ARESETN <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            read_checked(4'(i * 4), 0, 0);
        end

        // Byte strobes, unaligned low address bits
        for (int i = 0; i < 40; i++) begin
            addr = {2'(rand_below(3)), 2'(rand_below(4))};
            write_checked(addr, rand_word(), 2'(rand_below(4)), rand_below(3), rand_below(3),
                          rand_below(3), 1'b0, 4'd0);
            read_checked(addr, rand_below(3), rand_below(3));
        end

        // All four operations, amount zero every fifth triple
        for (int i = 0; i < 200; i++) begin
            write_checked(`REG_DATA_OFFSET, rand_word(), 2'b11, rand_below(3), rand_below(3),
                          0, 1'b0, 4'd0);
            data = rand_word();
            if (i % 5 == 0) data[3:0] = 4'd0;
            write_checked(`REG_SHIFT_OFFSET, data, 2'b01, 0, rand_below(3), 0, 1'b0, 4'd0);
            data = rand_word();
            data[1:0] = 2'(i % 4);
            write_checked(`REG_MODE_OFFSET, data, 2'b01, rand_below(3), 0, 0, 1'b0, 4'd0);
            read_checked(`REG_RESULT_OFFSET, 0, rand_below(2));
        end

        // Result register is read only
        for (int i = 0; i < 4; i++) begin
            write_checked(`REG_RESULT_OFFSET, rand_word(), 2'b11, 0, 0, 0, 1'b0, 4'd0);
            read_checked(`REG_RESULT_OFFSET, rand_below(3), 0);
        end

        // AW first, W first, then both together
        for (int i = 0; i < 30; i++) begin
            addr = {2'(rand_below(3)), 2'b00};
            dly  = 1 + rand_below(4);
            case (i % 3)
                0:       write_checked(addr, rand_word(), 2'(rand_below(4)), 0, dly, 0,
                                       1'b0, 4'd0);
                1:       write_checked(addr, rand_word(), 2'(rand_below(4)), dly, 0, 0,
                                       1'b0, 4'd0);
                default: write_checked(addr, rand_word(), 2'(rand_below(4)), dly, dly, 0,
                                       1'b0, 4'd0);
            endcase
            read_checked(addr, rand_below(3), 0);
        end

        // Stalled B and R, second address waiting on the bus
        for (int i = 0; i < 20; i++) begin
            addr      = {2'(rand_below(3)), 2'b00};
            next_addr = {2'(rand_below(3)), 2'b00};
            write_checked(addr, rand_word(), 2'(rand_below(4)), 0, 0, 2 + rand_below(6),
                          1'b1, next_addr);
            write_checked(next_addr, rand_word(), 2'(rand_below(4)), 0, rand_below(3),
                          rand_below(3), 1'b0, 4'd0);
            read_checked(next_addr, 0, 2 + rand_below(6));
            read_checked(`REG_RESULT_OFFSET, rand_below(2), 2 + rand_below(6));
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/shifter_pkg.sv
logic/axil_write_port.sv
logic/axil_read_port.sv
logic/shifter_regs.sv
logic/barrel_shifter.sv
logic/axil_shifter.sv
testbench/tb_axil_shifter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_axil_shifter -f build.f -o tb_axil_shifter \
    > build.log 2>&1 || { cat build.log; echo "build error, see build.log"; exit 1; }

./obj_dir/tb_axil_shifter > "$LOG" 2>&1
cat "$LOG"

grep -q "test failed" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" "$LOG" && exit 0 || { echo "simulation ended without a result"; exit 1; }
